//--- common/rvv_alu_pkg.sv
`default_nettype none

package rvv_alu_pkg;

  // datapath sizing
  localparam int VLEN            = 128;
  localparam int VLENB           = VLEN / 8;
  localparam int BYTE_IDX_WIDTH  = $clog2(VLENB);
  localparam int ROB_DEPTH_WIDTH = 4;
  localparam int VSTART_WIDTH    = 7;
  localparam int FUNCT3_WIDTH    = 3;

  // funct3 categories handled by this slice
  localparam logic [FUNCT3_WIDTH-1:0] OPIVV = 3'b000;
  localparam logic [FUNCT3_WIDTH-1:0] OPMVV = 3'b010;

  // funct6[5:3] shared by all mask-logical opcodes
  localparam logic [2:0] MASK_GROUP = 3'b011;

  typedef enum logic [1:0] {
    EEW8    = 2'b00,
    EEW16   = 2'b01,
    EEW32   = 2'b10,
    EEW_RSV = 2'b11
  } EEW_e;

  typedef enum logic [5:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMANDN = 6'b011000,
    VMAND  = 6'b011001,
    VMOR   = 6'b011010,
    VMXOR  = 6'b011011,
    VMORN  = 6'b011100,
    VMNAND = 6'b011101,
    VMNOR  = 6'b011110,
    VMXNOR = 6'b011111
  } ALU_FUNCT6_e;

  // low three funct6 bits within the mask group, same order as the opcodes
  typedef enum logic [2:0] {
    SEL_ANDN = 3'd0,
    SEL_AND  = 3'd1,
    SEL_OR   = 3'd2,
    SEL_XOR  = 3'd3,
    SEL_ORN  = 3'd4,
    SEL_NAND = 3'd5,
    SEL_NOR  = 3'd6,
    SEL_XNOR = 3'd7
  } MASK_SEL_e;

  // funct6 seen either as a full opcode or as group + selector
  typedef union packed {
    ALU_FUNCT6_e ari_funct6;
    struct packed {
      logic [2:0] group;
      MASK_SEL_e  sel;
    } mask_funct6;
  } FUNCT6_u;

  // 2'b11 is never produced
  typedef enum logic [1:0] {
    ADD  = 2'b00,
    SUB  = 2'b01,
    RSUB = 2'b10
  } ADDSUB_OP_e;

  // destination register file of a result
  typedef enum logic [0:0] {
    VRF = 1'b0,
    XRF = 1'b1
  } W_TYPE_e;

endpackage

`default_nettype wire

//--- hdl/rvv_alu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_ctrl (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      uop_valid,
  input  logic [rvv_alu_pkg::ROB_DEPTH_WIDTH-1:0]   rob_entry,
  input  rvv_alu_pkg::FUNCT6_u                      uop_funct6,
  input  logic [rvv_alu_pkg::FUNCT3_WIDTH-1:0]      uop_funct3,
  input  logic                                      vm,
  input  rvv_alu_pkg::EEW_e                         vd_eew,
  input  logic [rvv_alu_pkg::VLEN-1:0]              mask_w_data,
  input  logic [rvv_alu_pkg::VLEN-1:0]              addsub_w_data,
  output rvv_alu_pkg::ADDSUB_OP_e                   addsub_op,
  output logic                                      result_valid,
  output logic [rvv_alu_pkg::ROB_DEPTH_WIDTH-1:0]   result_rob_entry,
  output logic [rvv_alu_pkg::VLEN-1:0]              result_w_data,
  output rvv_alu_pkg::W_TYPE_e                      result_w_type,
  output logic                                      result_w_valid,
  output logic                                      result_ignore_vta,
  output logic                                      result_ignore_vma
);

  import rvv_alu_pkg::*;

  logic            is_mask_op;
  logic            is_addsub_op;
  logic            mask_legal;
  logic            addsub_legal;
  logic [VLEN-1:0] sel_w_data;

  // mask group is recognized through the group/selector view
  assign is_mask_op = (uop_funct3 == OPMVV) &&
                      (uop_funct6.mask_funct6.group == MASK_GROUP);

  // arithmetic opcodes through the full opcode view
  always_comb begin
    addsub_op    = ADD;
    is_addsub_op = 1'b0;
    if (uop_funct3 == OPIVV) begin
      case (uop_funct6.ari_funct6)
        VADD: begin
          addsub_op    = ADD;
          is_addsub_op = 1'b1;
        end
        VSUB: begin
          addsub_op    = SUB;
          is_addsub_op = 1'b1;
        end
        VRSUB: begin
          addsub_op    = RSUB;
          is_addsub_op = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // mask-logical ops are unmasked only
  assign mask_legal   = is_mask_op & vm;
  assign addsub_legal = is_addsub_op & (vd_eew != EEW_RSV);

  // illegal uops write zero data
  assign sel_w_data = mask_legal   ? mask_w_data   :
                      addsub_legal ? addsub_w_data : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid      <= 1'b0;
      result_rob_entry  <= '0;
      result_w_data     <= '0;
      result_w_type     <= VRF;
      result_w_valid    <= 1'b0;
      result_ignore_vta <= 1'b0;
      result_ignore_vma <= 1'b0;
    end else begin
      result_valid <= uop_valid;
      if (uop_valid) begin
        result_rob_entry  <= rob_entry;
        result_w_data     <= sel_w_data;
        result_w_type     <= VRF;
        result_w_valid    <= mask_legal | addsub_legal;
        // mask results are tail-agnostic, never mask-agnostic
        result_ignore_vta <= mask_legal;
        result_ignore_vma <= 1'b0;
      end else begin
        result_w_valid <= 1'b0;
      end
    end
  end

  // a result only ever answers the uop of the previous cycle
  a_result_after_uop: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> $past(uop_valid))
    else $error("result_valid without a uop one cycle earlier");

  a_wvalid_in_result: assert property (@(posedge clk) disable iff (!rst_n)
    result_w_valid |-> result_valid)
    else $error("result_w_valid high outside a result cycle");

endmodule

`default_nettype wire

//--- hdl/rvv_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_top (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      uop_valid,
  input  logic [rvv_alu_pkg::ROB_DEPTH_WIDTH-1:0]   rob_entry,
  input  rvv_alu_pkg::FUNCT6_u                      uop_funct6,
  input  logic [rvv_alu_pkg::FUNCT3_WIDTH-1:0]      uop_funct3,
  input  logic                                      vm,
  input  logic [rvv_alu_pkg::VSTART_WIDTH-1:0]      vstart,
  input  rvv_alu_pkg::EEW_e                         vd_eew,
  input  logic [rvv_alu_pkg::VLENB-1:0]             v0_data,
  input  logic [rvv_alu_pkg::VLEN-1:0]              vd_data,
  input  logic [rvv_alu_pkg::VLEN-1:0]              vs1_data,
  input  logic [rvv_alu_pkg::VLEN-1:0]              vs2_data,
  output logic                                      result_valid,
  output logic [rvv_alu_pkg::ROB_DEPTH_WIDTH-1:0]   result_rob_entry,
  output logic [rvv_alu_pkg::VLEN-1:0]              result_w_data,
  output rvv_alu_pkg::W_TYPE_e                      result_w_type,
  output logic                                      result_w_valid,
  output logic                                      result_ignore_vta,
  output logic                                      result_ignore_vma
);

  import rvv_alu_pkg::*;

  ADDSUB_OP_e      addsub_op;
  logic [VLEN-1:0] mask_w_data;
  logic [VLEN-1:0] addsub_w_data;

  // decode, unit select and the single register stage
  rvv_alu_ctrl u_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .uop_valid         (uop_valid),
    .rob_entry         (rob_entry),
    .uop_funct6        (uop_funct6),
    .uop_funct3        (uop_funct3),
    .vm                (vm),
    .vd_eew            (vd_eew),
    .mask_w_data       (mask_w_data),
    .addsub_w_data     (addsub_w_data),
    .addsub_op         (addsub_op),
    .result_valid      (result_valid),
    .result_rob_entry  (result_rob_entry),
    .result_w_data     (result_w_data),
    .result_w_type     (result_w_type),
    .result_w_valid    (result_w_valid),
    .result_ignore_vta (result_ignore_vta),
    .result_ignore_vma (result_ignore_vma)
  );

  // selector comes straight from the low funct6 bits
  rvv_alu_unit_mask u_mask (
    .mask_sel    (uop_funct6.mask_funct6.sel),
    .vstart      (vstart),
    .vd_data     (vd_data),
    .vs1_data    (vs1_data),
    .vs2_data    (vs2_data),
    .mask_w_data (mask_w_data)
  );

  rvv_alu_unit_addsub u_addsub (
    .addsub_op     (addsub_op),
    .vd_eew        (vd_eew),
    .vm            (vm),
    .vstart        (vstart),
    .v0_data       (v0_data),
    .vd_data       (vd_data),
    .vs1_data      (vs1_data),
    .vs2_data      (vs2_data),
    .addsub_w_data (addsub_w_data)
  );

endmodule

`default_nettype wire

//--- hdl/rvv_alu_unit_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_unit_addsub (
  input  rvv_alu_pkg::ADDSUB_OP_e                addsub_op,
  input  rvv_alu_pkg::EEW_e                      vd_eew,
  input  logic                                   vm,
  input  logic [rvv_alu_pkg::VSTART_WIDTH-1:0]   vstart,
  input  logic [rvv_alu_pkg::VLENB-1:0]          v0_data,
  input  logic [rvv_alu_pkg::VLEN-1:0]           vd_data,
  input  logic [rvv_alu_pkg::VLEN-1:0]           vs1_data,
  input  logic [rvv_alu_pkg::VLEN-1:0]           vs2_data,
  output logic [rvv_alu_pkg::VLEN-1:0]           addsub_w_data
);

  import rvv_alu_pkg::*;

  logic [VLEN-1:0]           opa;
  logic [VLEN-1:0]           opb;
  logic                      sub_cin;
  logic                      eew_ok;
  logic [1:0]                eew_shift;
  logic [BYTE_IDX_WIDTH-1:0] lane_mask;

  // subtraction is a + ~b + 1, rsub swaps the operands first
  always_comb begin
    opa     = vs2_data;
    opb     = vs1_data;
    sub_cin = 1'b0;
    case (addsub_op)
      SUB: begin
        opb     = ~vs1_data;
        sub_cin = 1'b1;
      end
      RSUB: begin
        opa     = vs1_data;
        opb     = ~vs2_data;
        sub_cin = 1'b1;
      end
      default: ;
    endcase
  end

  // bytes per element as a shift, lane_mask marks bytes inside an element
  always_comb begin
    eew_ok    = 1'b1;
    eew_shift = 2'd0;
    lane_mask = '0;
    case (vd_eew)
      EEW8: begin
        eew_shift = 2'd0;
        lane_mask = BYTE_IDX_WIDTH'(0);
      end
      EEW16: begin
        eew_shift = 2'd1;
        lane_mask = BYTE_IDX_WIDTH'(1);
      end
      EEW32: begin
        eew_shift = 2'd2;
        lane_mask = BYTE_IDX_WIDTH'(3);
      end
      default: begin
        eew_ok = 1'b0;
      end
    endcase
  end

  // byte-sliced adder, carry is cut at every element start
  always_comb begin
    logic [8:0]                byte_sum;
    logic                      carry;
    logic [BYTE_IDX_WIDTH-1:0] byte_idx;
    logic [BYTE_IDX_WIDTH-1:0] elem_idx;
    logic                      keep_vd;
    carry = 1'b0;
    for (int j = 0; j < VLENB; j++) begin
      byte_idx = BYTE_IDX_WIDTH'(j);
      if ((byte_idx & lane_mask) == '0) begin
        carry = sub_cin;
      end
      byte_sum = {1'b0, opa[j*8 +: 8]} + {1'b0, opb[j*8 +: 8]} + {8'd0, carry};
      carry    = byte_sum[8];
      // element number doubles as the v0 bit index
      elem_idx = byte_idx >> eew_shift;
      keep_vd  = (VSTART_WIDTH'(elem_idx) < vstart) || (!vm && !v0_data[elem_idx]);
      if (keep_vd || !eew_ok) begin
        addsub_w_data[j*8 +: 8] = vd_data[j*8 +: 8];
      end else begin
        addsub_w_data[j*8 +: 8] = byte_sum[7:0];
      end
    end
  end

  // decode in control must never hand over the spare encoding
  always_comb begin
    a_op_encoding: assert (addsub_op != 2'b11)
      else $error("addsub_op holds the unused encoding");
  end

endmodule

`default_nettype wire

//--- hdl/rvv_alu_unit_mask.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_alu_unit_mask (
  input  rvv_alu_pkg::MASK_SEL_e                 mask_sel,
  input  logic [rvv_alu_pkg::VSTART_WIDTH-1:0]   vstart,
  input  logic [rvv_alu_pkg::VLEN-1:0]           vd_data,
  input  logic [rvv_alu_pkg::VLEN-1:0]           vs1_data,
  input  logic [rvv_alu_pkg::VLEN-1:0]           vs2_data,
  output logic [rvv_alu_pkg::VLEN-1:0]           mask_w_data
);

  import rvv_alu_pkg::*;

  logic [VLEN-1:0] logic_res;
  logic [VLEN-1:0] prefix_mask;

  // boolean function of vs2 against vs1
  always_comb begin
    case (mask_sel)
      SEL_ANDN: begin
        logic_res = vs2_data & ~vs1_data;
      end
      SEL_AND: begin
        logic_res = vs2_data & vs1_data;
      end
      SEL_OR: begin
        logic_res = vs2_data | vs1_data;
      end
      SEL_XOR: begin
        logic_res = vs2_data ^ vs1_data;
      end
      SEL_ORN: begin
        logic_res = vs2_data | ~vs1_data;
      end
      SEL_NAND: begin
        logic_res = ~(vs2_data & vs1_data);
      end
      SEL_NOR: begin
        logic_res = ~(vs2_data | vs1_data);
      end
      SEL_XNOR: begin
        logic_res = ~(vs2_data ^ vs1_data);
      end
      default: begin
        logic_res = '0;
      end
    endcase
  end

  // one mask element per bit, so vstart counts bits here
  always_comb begin
    for (int i = 0; i < VLEN; i++) begin
      prefix_mask[i] = (VSTART_WIDTH'(i) < vstart);
    end
  end

  // bits below vstart are left as they were in vd
  assign mask_w_data = (vd_data & prefix_mask) | (logic_res & ~prefix_mask);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_rvv_alu -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/Vtb_rvv_alu 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" <<< "$output"; then
  exit 0
else
  echo "pass message not found"
  exit 1
fi

//--- tb.f
common/rvv_alu_pkg.sv
hdl/rvv_alu_ctrl.sv
hdl/rvv_alu_unit_mask.sv
hdl/rvv_alu_unit_addsub.sv
hdl/rvv_alu_top.sv
tb/tb_rvv_alu.sv

//--- tb/tb_rvv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_alu;

  import rvv_alu_pkg::*;

  localparam int          CLK_PERIOD  = 40;
  localparam int          IN_DELAY    = 5;
  localparam int          NUM_RANDOM  = 400;
  localparam int          DRAIN_LIMIT = 10;
  localparam logic [31:0] SEED        = 32'h9881_ef01;

  logic                       clk;
  logic                       rst_n;
  logic                       uop_valid;
  logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
  FUNCT6_u                    uop_funct6;
  logic [FUNCT3_WIDTH-1:0]    uop_funct3;
  logic                       vm;
  logic [VSTART_WIDTH-1:0]    vstart;
  EEW_e                       vd_eew;
  logic [VLENB-1:0]           v0_data;
  logic [VLEN-1:0]            vd_data;
  logic [VLEN-1:0]            vs1_data;
  logic [VLEN-1:0]            vs2_data;
  logic                       result_valid;
  logic [ROB_DEPTH_WIDTH-1:0] result_rob_entry;
  logic [VLEN-1:0]            result_w_data;
  W_TYPE_e                    result_w_type;
  logic                       result_w_valid;
  logic                       result_ignore_vta;
  logic                       result_ignore_vma;

  // expected outputs for the uop just driven, and for the registered stage
  logic                       nxt_valid;
  logic                       nxt_w_valid;
  logic                       nxt_vta;
  logic [ROB_DEPTH_WIDTH-1:0] nxt_rob;
  logic [VLEN-1:0]            nxt_data;
  logic                       exp_valid;
  logic                       exp_w_valid;
  logic                       exp_vta;
  logic [ROB_DEPTH_WIDTH-1:0] exp_rob;
  logic [VLEN-1:0]            exp_data;

  rvv_alu_top dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_mismatch(input string name, input logic [VLEN-1:0] got,
                                 input logic [VLEN-1:0] want);
    $display("mismatch %s: got %h expected %h", name, got, want);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  // one bit per mask element, functions in funct6 order
  function automatic logic [VLEN-1:0] mask_logic_result(input logic [2:0] sel,
      input logic [VSTART_WIDTH-1:0] vst, input logic [VLEN-1:0] vd,
      input logic [VLEN-1:0] vs1, input logic [VLEN-1:0] vs2);
    logic [VLEN-1:0] res;
    logic            r;
    for (int i = 0; i < VLEN; i++) begin
      case (sel)
        3'd0: r = vs2[i] & ~vs1[i];
        3'd1: r = vs2[i] & vs1[i];
        3'd2: r = vs2[i] | vs1[i];
        3'd3: r = vs2[i] ^ vs1[i];
        3'd4: r = vs2[i] | ~vs1[i];
        3'd5: r = ~(vs2[i] & vs1[i]);
        3'd6: r = ~(vs2[i] | vs1[i]);
        default: r = ~(vs2[i] ^ vs1[i]);
      endcase
      res[i] = (i < int'(vst)) ? vd[i] : r;
    end
    return res;
  endfunction

  // element-wise, only the low ew bits of the 32-bit result are kept
  function automatic logic [VLEN-1:0] addsub_result(input logic [5:0] f6,
      input logic [1:0] eew, input logic vm_in, input logic [VSTART_WIDTH-1:0] vst,
      input logic [VLENB-1:0] v0, input logic [VLEN-1:0] vd,
      input logic [VLEN-1:0] vs1, input logic [VLEN-1:0] vs2);
    logic [VLEN-1:0] res;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     r;
    int              ew;
    res = vd;
    ew  = 8 << eew;
    for (int e = 0; e < VLEN / ew; e++) begin
      a = '0;
      b = '0;
      for (int k = 0; k < ew; k++) begin
        a[k] = vs2[e*ew + k];
        b[k] = vs1[e*ew + k];
      end
      if (f6 == 6'(VSUB)) begin
        r = a - b;
      end else if (f6 == 6'(VRSUB)) begin
        r = b - a;
      end else begin
        r = a + b;
      end
      if (e >= int'(vst) && (vm_in || v0[e])) begin
        for (int k = 0; k < ew; k++) begin
          res[e*ew + k] = r[k];
        end
      end
    end
    return res;
  endfunction

  function automatic logic [5:0] addsub_code(input int idx);
    case (idx)
      0: return 6'(VADD);
      1: return 6'(VSUB);
      default: return 6'(VRSUB);
    endcase
  endfunction

  function automatic logic [VLEN-1:0] random_vreg();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic logic [VLENB-1:0] random_v0();
    return VLENB'($urandom);
  endfunction

  // zero, small or anywhere in the register
  function automatic logic [VSTART_WIDTH-1:0] pick_vstart();
    case ($urandom % 3)
      0: return '0;
      1: return VSTART_WIDTH'($urandom % 20);
      default: return VSTART_WIDTH'($urandom);
    endcase
  endfunction

  task automatic drive_uop(input logic valid, input logic [ROB_DEPTH_WIDTH-1:0] rob,
      input logic [5:0] f6, input logic [FUNCT3_WIDTH-1:0] f3, input logic vm_in,
      input logic [VSTART_WIDTH-1:0] vst, input logic [1:0] eew,
      input logic [VLENB-1:0] v0, input logic [VLEN-1:0] vd,
      input logic [VLEN-1:0] vs1, input logic [VLEN-1:0] vs2);
    logic mask_ok;
    logic add_ok;
    @(posedge clk);
    #IN_DELAY;
    uop_valid             = valid;
    rob_entry             = rob;
    uop_funct6.ari_funct6 = ALU_FUNCT6_e'(f6);
    uop_funct3            = f3;
    vm                    = vm_in;
    vstart                = vst;
    vd_eew                = EEW_e'(eew);
    v0_data               = v0;
    vd_data               = vd;
    vs1_data              = vs1;
    vs2_data              = vs2;
    mask_ok = (f3 == OPMVV) && (f6[5:3] == MASK_GROUP) && vm_in;
    add_ok  = (f3 == OPIVV) && (eew != 2'b11) &&
              (f6 == 6'(VADD) || f6 == 6'(VSUB) || f6 == 6'(VRSUB));
    nxt_valid   = valid;
    nxt_rob     = rob;
    nxt_w_valid = mask_ok || add_ok;
    nxt_vta     = mask_ok;
    if (mask_ok) begin
      nxt_data = mask_logic_result(f6[2:0], vst, vd, vs1, vs2);
    end else if (add_ok) begin
      nxt_data = addsub_result(f6, eew, vm_in, vst, v0, vd, vs1, vs2);
    end else begin
      nxt_data = '0;
    end
  endtask

  task automatic drive_idle();
    drive_uop(1'b0, '0, '0, '0, 1'b0, '0, 2'd0, '0, '0, '0, '0);
  endtask

  task automatic run_directed();
    // every mask function from element 0, then again with a late vstart
    for (int s = 0; s < 16; s++) begin
      drive_uop(1'b1, ROB_DEPTH_WIDTH'(s), {MASK_GROUP, 3'(s)}, OPMVV, 1'b1,
                (s < 8) ? '0 : VSTART_WIDTH'(127 - (s - 8) * 5), 2'd0, random_v0(),
                random_vreg(), random_vreg(), random_vreg());
    end
    // all ones against 1 wraps in every element, then masked with small vstart
    for (int o = 0; o < 3; o++) begin
      for (int w = 0; w < 3; w++) begin
        drive_uop(1'b1, ROB_DEPTH_WIDTH'(o * 3 + w), addsub_code(o), OPIVV, 1'b1, '0,
                  2'(w), '0, random_vreg(), {VLENB{8'h01}}, {VLEN{1'b1}});
        drive_uop(1'b1, ROB_DEPTH_WIDTH'(o * 3 + w + 7), addsub_code(o), OPIVV, 1'b0,
                  VSTART_WIDTH'(1 + w), 2'(w), random_v0(), random_vreg(), random_vreg(),
                  random_vreg());
      end
    end
    // unknown funct6, masked mask op, reserved eew
    drive_uop(1'b1, 4'h3, 6'b000100, OPIVV, 1'b1, '0, 2'd0, '0, random_vreg(),
              random_vreg(), random_vreg());
    drive_uop(1'b1, 4'h4, 6'(VMAND), OPMVV, 1'b0, '0, 2'd0, '0, random_vreg(),
              random_vreg(), random_vreg());
    drive_uop(1'b1, 4'h5, 6'(VADD), OPIVV, 1'b1, '0, 2'b11, '0, random_vreg(),
              random_vreg(), random_vreg());
  endtask

  task automatic send_random();
    int                      kind;
    logic [5:0]              f6;
    logic [FUNCT3_WIDTH-1:0] f3;
    logic                    vm_r;
    logic [1:0]              eew;
    kind = int'($urandom % 4);
    f6   = addsub_code(int'($urandom % 3));
    f3   = OPIVV;
    vm_r = 1'($urandom);
    eew  = 2'($urandom % 3);
    case (kind)
      1: begin
        f6   = {MASK_GROUP, 3'($urandom)};
        f3   = OPMVV;
        vm_r = 1'b1;
      end
      3: begin
        case ($urandom % 3)
          0: f6 = 6'(4 + $urandom % 60);
          1: begin
            f6   = {MASK_GROUP, 3'($urandom)};
            f3   = OPMVV;
            vm_r = 1'b0;
          end
          default: eew = 2'b11;
        endcase
      end
      default: ;
    endcase
    drive_uop(kind != 0, ROB_DEPTH_WIDTH'($urandom), f6, f3, vm_r, pick_vstart(), eew,
              random_v0(), random_vreg(), random_vreg(), random_vreg());
  endtask

  // registered copy of the expected values, same stage as the DUT
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_valid   <= 1'b0;
      exp_w_valid <= 1'b0;
    end else begin
      exp_valid   <= nxt_valid;
      exp_w_valid <= nxt_valid & nxt_w_valid;
      if (nxt_valid) begin
        exp_rob  <= nxt_rob;
        exp_data <= nxt_data;
        exp_vta  <= nxt_vta;
      end
    end
  end

  a_valid: assert property (@(posedge clk) disable iff (!rst_n) result_valid == exp_valid)
    else report_mismatch("result_valid", VLEN'($sampled(result_valid)),
                         VLEN'($sampled(exp_valid)));

  a_w_valid: assert property (@(posedge clk) disable iff (!rst_n)
    result_w_valid == exp_w_valid)
    else report_mismatch("result_w_valid", VLEN'($sampled(result_w_valid)),
                         VLEN'($sampled(exp_w_valid)));

  a_rob: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> result_rob_entry == exp_rob)
    else report_mismatch("result_rob_entry", VLEN'($sampled(result_rob_entry)),
                         VLEN'($sampled(exp_rob)));

  a_data: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> result_w_data == exp_data)
    else report_mismatch("result_w_data", $sampled(result_w_data), $sampled(exp_data));

  a_w_type: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> result_w_type == VRF)
    else report_mismatch("result_w_type", VLEN'($sampled(result_w_type)), VLEN'(VRF));

  a_vta: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> result_ignore_vta == exp_vta)
    else report_mismatch("result_ignore_vta", VLEN'($sampled(result_ignore_vta)),
                         VLEN'($sampled(exp_vta)));

  a_vma: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> !result_ignore_vma)
    else report_mismatch("result_ignore_vma", VLEN'($sampled(result_ignore_vma)), '0);

  initial begin
    int unsigned                seed_state;
    logic                       seen;
    logic [ROB_DEPTH_WIDTH-1:0] last_rob;
    seed_state            = $urandom(SEED);
    clk                   = 1'b0;
    rst_n                 = 1'b0;
    uop_valid             = 1'b0;
    rob_entry             = '0;
    uop_funct6.ari_funct6 = VADD;
    uop_funct3            = '0;
    vm                    = 1'b0;
    vstart                = '0;
    vd_eew                = EEW8;
    v0_data               = '0;
    vd_data               = '0;
    vs1_data              = '0;
    vs2_data              = '0;
    nxt_valid             = 1'b0;
    nxt_w_valid           = 1'b0;
    nxt_vta               = 1'b0;
    nxt_rob               = '0;
    nxt_data              = '0;
    repeat (5) @(posedge clk);
    #IN_DELAY;
    rst_n = 1'b1;
    // quiet cycles, no result may appear
    repeat (3) drive_idle();
    run_directed();
    repeat (NUM_RANDOM) send_random();
    last_rob = 4'hA;
    drive_uop(1'b1, last_rob, 6'(VADD), OPIVV, 1'b1, '0, 2'd0, '0, random_vreg(),
              random_vreg(), random_vreg());
    seen = 1'b0;
    for (int c = 0; c < DRAIN_LIMIT && !seen; c++) begin
      drive_idle();
      seen = result_valid && (result_rob_entry == last_rob);
    end
    if (!seen) begin
      report_failure("timed out waiting for the last result");
    end else begin
      // let the checks see the final result cycle
      repeat (2) drive_idle();
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
